//--- rtl/pipe_pkg.sv
//********************
// Shared types and constants for the pipeline control block.
// Holds the decoded-instruction struct, the payload carried by every
// stage register, and the RV32I opcode and system-word encodings.
// Modules take it with a wildcard import in their header.
//********************

package pipe_pkg;

    // Architectural register index
    typedef logic [4:0] reg_addr_t;

    // Decoder output, 22 bits
    typedef struct packed {
        reg_addr_t rs1;
        logic      en_rs1;
        reg_addr_t rs2;
        logic      en_rs2;
        reg_addr_t rd;
        logic      en_rd;
        logic      is_load;
        logic      is_store;
        logic      is_mret;
        logic      is_ecall;
    } decoded_inst_t;

    // What each stage register carries, 54 bits
    typedef struct packed {
        decoded_inst_t deco;
        logic [31:0]   pc;
    } stage_payload_t;

    // RV32I major opcodes
    localparam logic [6:0] op_lui    = 7'b0110111;
    localparam logic [6:0] op_auipc  = 7'b0010111;
    localparam logic [6:0] op_jal    = 7'b1101111;
    localparam logic [6:0] op_jalr   = 7'b1100111;
    localparam logic [6:0] op_branch = 7'b1100011;
    localparam logic [6:0] op_load   = 7'b0000011;
    localparam logic [6:0] op_store  = 7'b0100011;
    localparam logic [6:0] op_op_imm = 7'b0010011;
    localparam logic [6:0] op_op     = 7'b0110011;
    localparam logic [6:0] op_system = 7'b1110011;

    // Full-word encodings matched by the decoder
    localparam logic [31:0] mret_word  = 32'h3020_0073;
    localparam logic [31:0] ecall_word = 32'h0000_0073;

endpackage

//--- rtl/inst_decoder.sv
//********************
// Combinational RV32I decoder for the pipeline control.
// Turns a raw instruction word into the register usage and the
// few flags the hazard logic needs. No clock, no state.
//********************

module inst_decoder import pipe_pkg::*; (
    input  logic [31:0]   inst,
    output decoded_inst_t deco
);

    logic [6:0] opcode;
    logic [2:0] funct3;

    assign opcode = inst[6:0];
    assign funct3 = inst[14:12];

    always_comb begin
        deco = '0;

        // Register fields sit at fixed positions in every format
        deco.rs1 = inst[19:15];
        deco.rs2 = inst[24:20];
        deco.rd  = inst[11:7];

        case (opcode)
            op_lui, op_auipc, op_jal: begin
                deco.en_rd = 1'b1;
            end
            op_jalr: begin
                deco.en_rs1 = 1'b1;
                deco.en_rd  = 1'b1;
            end
            op_branch: begin
                deco.en_rs1 = 1'b1;
                deco.en_rs2 = 1'b1;
            end
            op_load: begin
                deco.en_rs1  = 1'b1;
                deco.en_rd   = 1'b1;
                deco.is_load = 1'b1;
            end
            op_store: begin
                deco.en_rs1   = 1'b1;
                deco.en_rs2   = 1'b1;
                deco.is_store = 1'b1;
            end
            op_op_imm: begin
                deco.en_rs1 = 1'b1;
                deco.en_rd  = 1'b1;
            end
            op_op: begin
                deco.en_rs1 = 1'b1;
                deco.en_rs2 = 1'b1;
                deco.en_rd  = 1'b1;
            end
            op_system: begin
                // CSR accesses write rd; the immediate forms have no rs1
                if (funct3 != 3'b000) begin
                    deco.en_rd  = 1'b1;
                    deco.en_rs1 = !funct3[2];
                end
            end
            default: begin
                deco.en_rd = 1'b0;
            end
        endcase

        // x0 is never a real destination
        if (deco.rd == '0) begin
            deco.en_rd = 1'b0;
        end

        deco.is_mret  = (inst == mret_word);
        deco.is_ecall = (inst == ecall_word);
    end

endmodule

//--- rtl/stage_reg.sv
//********************
// One pipeline stage register: a valid bit plus a payload.
// Hold, bubble and flush come from the hazard unit. The payload
// type is a parameter so the same block serves any stage contents.
//********************

module stage_reg #(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     rst,
    input  logic     stall,
    input  logic     prev_stall,
    input  logic     flush,
    input  logic     in_valid,
    input  payload_t in_payload,
    output logic     out_valid,
    output payload_t out_payload
);

    // Control state, priority reset > flush > hold > bubble > load
    always_ff @(posedge clk) begin
        if (rst) begin
            out_valid <= 1'b0;
        end else if (flush) begin
            out_valid <= 1'b0;
        end else if (!stall) begin
            // Upstream held back means nothing moves in this cycle
            out_valid <= prev_stall ? 1'b0 : in_valid;
        end
    end

    // Payload only matters while valid, so it just follows the load case
    always_ff @(posedge clk) begin
        if (!stall && !prev_stall) begin
            out_payload <= in_payload;
        end
    end

endmodule

//--- rtl/hazard_unit.sv
//********************
// Hazard detection across the ID, EX, MEM and WB stages.
// Raises read-after-write interlocks (no forwarding), the mret drain,
// data-cache waits in MEM and the ecall hold in WB. Every stall
// output includes all stalls further down the pipe.
//********************

module hazard_unit import pipe_pkg::*; (
    input  stage_payload_t id_payload,
    input  stage_payload_t ex_payload,
    input  stage_payload_t mem_payload,
    input  stage_payload_t wb_payload,

    input  logic           id_valid,
    input  logic           ex_valid,
    input  logic           mem_valid,
    input  logic           wb_valid,

    // Memory stage levels
    input  logic           dcache_valid,
    input  logic           write_done,
    input  logic           dcache_enable,

    // WB stage level
    input  logic           ecall_stall,

    output logic           id_stall,
    output logic           ex_stall,
    output logic           mem_stall,
    output logic           wb_stall,
    output logic           flush_before_wb
);

    logic raw_ex;
    logic raw_mem;
    logic raw_wb;
    logic mret_drain;
    logic id_hold;
    logic mem_wait;
    logic wb_hold;

    // True when dst writes a register that src reads
    function automatic logic reads_dest(decoded_inst_t src, decoded_inst_t dst);
        logic hit_rs1;
        logic hit_rs2;
        hit_rs1 = src.en_rs1 && (src.rs1 == dst.rd);
        hit_rs2 = src.en_rs2 && (src.rs2 == dst.rd);
        return dst.en_rd && (hit_rs1 || hit_rs2);
    endfunction

    assign raw_ex  = ex_valid  && reads_dest(id_payload.deco, ex_payload.deco);
    assign raw_mem = mem_valid && reads_dest(id_payload.deco, mem_payload.deco);
    assign raw_wb  = wb_valid  && reads_dest(id_payload.deco, wb_payload.deco);

    // mret waits until everything older has left the pipe
    assign mret_drain = id_payload.deco.is_mret && (ex_valid || mem_valid || wb_valid);

    assign id_hold = id_valid && (mret_drain || raw_ex || raw_mem || raw_wb);

    // Enable gates both the load and the store wait
    assign mem_wait = mem_valid && dcache_enable &&
                      ((mem_payload.deco.is_load  && !dcache_valid) ||
                       (mem_payload.deco.is_store && !write_done));

    assign wb_hold = ecall_stall;

    // Chain from WB back toward ID
    assign wb_stall  = wb_hold;
    assign mem_stall = mem_wait || wb_stall;
    assign ex_stall  = mem_stall;
    assign id_stall  = id_hold || ex_stall;

    // Younger stages are squashed while an ecall sits in WB
    assign flush_before_wb = wb_valid && wb_payload.deco.is_ecall;

endmodule

//--- rtl/pipeline_ctrl.sv
//********************
// Top of the pipeline control for a five-stage RV32I core.
// Decodes the fetched word, walks it through the ID, EX, MEM and WB
// stage registers under hazard control and reports each retire.
// Fetch offers a word with inst_valid and must hold it while
// inst_ready is low.
//********************

module pipeline_ctrl import pipe_pkg::*; (
    input  logic        clk,
    input  logic        rst,

    // Fetch side
    input  logic        inst_valid,
    input  logic [31:0] inst,
    input  logic [31:0] inst_pc,
    output logic        inst_ready,

    // Memory and WB levels
    input  logic        dcache_enable,
    input  logic        dcache_valid,
    input  logic        write_done,
    input  logic        ecall_stall,

    output logic        id_stall,
    output logic        ex_stall,
    output logic        mem_stall,
    output logic        wb_stall,
    output logic        flush_before_wb,

    // Retire port
    output logic        retire_valid,
    output logic [31:0] retire_pc,
    output reg_addr_t   retire_rd,
    output logic        retire_en_rd
);

    decoded_inst_t  fetch_deco;
    stage_payload_t fetch_payload;

    logic           id_valid;
    logic           ex_valid;
    logic           mem_valid;
    logic           wb_valid;
    stage_payload_t id_payload;
    stage_payload_t ex_payload;
    stage_payload_t mem_payload;
    stage_payload_t wb_payload;

    inst_decoder u_decoder (
        .inst (inst),
        .deco (fetch_deco)
    );

    assign fetch_payload.deco = fetch_deco;
    assign fetch_payload.pc   = inst_pc;

    // Fetch has no stage register here, so nothing upstream of ID stalls
    stage_reg #(.payload_t(stage_payload_t)) id_reg (
        .clk         (clk),
        .rst         (rst),
        .stall       (id_stall),
        .prev_stall  (1'b0),
        .flush       (flush_before_wb),
        .in_valid    (inst_valid),
        .in_payload  (fetch_payload),
        .out_valid   (id_valid),
        .out_payload (id_payload)
    );

    stage_reg #(.payload_t(stage_payload_t)) ex_reg (
        .clk         (clk),
        .rst         (rst),
        .stall       (ex_stall),
        .prev_stall  (id_stall),
        .flush       (flush_before_wb),
        .in_valid    (id_valid),
        .in_payload  (id_payload),
        .out_valid   (ex_valid),
        .out_payload (ex_payload)
    );

    stage_reg #(.payload_t(stage_payload_t)) mem_reg (
        .clk         (clk),
        .rst         (rst),
        .stall       (mem_stall),
        .prev_stall  (ex_stall),
        .flush       (flush_before_wb),
        .in_valid    (ex_valid),
        .in_payload  (ex_payload),
        .out_valid   (mem_valid),
        .out_payload (mem_payload)
    );

    // The ecall itself stays in WB and is never flushed
    stage_reg #(.payload_t(stage_payload_t)) wb_reg (
        .clk         (clk),
        .rst         (rst),
        .stall       (wb_stall),
        .prev_stall  (mem_stall),
        .flush       (1'b0),
        .in_valid    (mem_valid),
        .in_payload  (mem_payload),
        .out_valid   (wb_valid),
        .out_payload (wb_payload)
    );

    hazard_unit u_hazard (
        .id_payload      (id_payload),
        .ex_payload      (ex_payload),
        .mem_payload     (mem_payload),
        .wb_payload      (wb_payload),
        .id_valid        (id_valid),
        .ex_valid        (ex_valid),
        .mem_valid       (mem_valid),
        .wb_valid        (wb_valid),
        .dcache_valid    (dcache_valid),
        .write_done      (write_done),
        .dcache_enable   (dcache_enable),
        .ecall_stall     (ecall_stall),
        .id_stall        (id_stall),
        .ex_stall        (ex_stall),
        .mem_stall       (mem_stall),
        .wb_stall        (wb_stall),
        .flush_before_wb (flush_before_wb)
    );

    assign inst_ready = !id_stall;

    assign retire_valid = wb_valid && !wb_stall;
    assign retire_pc    = wb_payload.pc;
    assign retire_rd    = wb_payload.deco.rd;
    assign retire_en_rd = wb_payload.deco.en_rd;

endmodule

//--- bench/tb_pipeline_ctrl.sv
//********************
// Self-checking testbench for the pipeline control top level.
// Offers a table of instructions to fetch in two passes, with the
// data cache enabled and then disabled, and checks every retire,
// its latency and the stall chain against a queue of accepted rows.
//********************

module tb_pipeline_ctrl import pipe_pkg::*; ();

    localparam int num_rows = 17;

    logic clk, rst, inst_valid, inst_ready, dcache_enable, dcache_valid, write_done;
    logic ecall_stall, id_stall, ex_stall, mem_stall, wb_stall, flush_before_wb;
    logic retire_valid, retire_en_rd;
    logic [31:0] inst, inst_pc, retire_pc;
    reg_addr_t retire_rd;

    // Table holds word, pc, dcache wait (0 = random), ecall hold, en_rd and latency
    logic [31:0] tbl_word[num_rows];
    logic [31:0] tbl_pc[num_rows];
    int          tbl_dwait[num_rows];
    int          tbl_ewait[num_rows];
    logic        tbl_en_rd[num_rows];
    int          tbl_lat[num_rows];
    int          n_rows = 0;

    int          acc_cyc[num_rows];
    int          wait_len[num_rows];
    logic        served[num_rows];
    int          q[$];
    int          mem_q[$];
    int          row, pass, cyc, mem_cnt, hold_cnt, errors, checks;
    logic        mem_go;
    logic [31:0] rng = 32'd17689;

    pipeline_ctrl uut (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    initial begin
        #(4 * (12 + 2 * num_rows * 40));
        $display("Watchdog expired: the pipeline stopped retiring, errors so far %0d", errors);
        $display("TESTBENCH FAILED");
        $finish;
    end

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        s = s ^ (s << 13);
        s = s ^ (s >> 17);
        s = s ^ (s << 5);
        return s;
    endfunction

    function automatic logic [31:0] enc_i(logic [6:0] op, reg_addr_t rd, reg_addr_t rs1,
                                          logic [11:0] imm);
        return {imm, rs1, (op == op_load) ? 3'b010 : 3'b000, rd, op};
    endfunction

    function automatic logic [31:0] enc_r(reg_addr_t rd, reg_addr_t rs1, reg_addr_t rs2);
        return {7'b0, rs2, rs1, 3'b000, rd, op_op};
    endfunction

    function automatic logic [31:0] enc_s(reg_addr_t rs2, reg_addr_t rs1, logic [4:0] imm);
        return {7'b0, rs2, rs1, 3'b010, imm, op_store};
    endfunction

    function automatic logic is_mem_op(logic [31:0] word);
        return (word[6:0] == op_load) || (word[6:0] == op_store);
    endfunction

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("MISMATCH %s: got %h expected %h at %0t", name, got, exp, $time);
        end
    endtask

    task automatic add_row(logic [31:0] word, int dwait, int ewait, logic en_rd, int lat);
        tbl_word[n_rows]  = word;
        tbl_pc[n_rows]    = 32'h0000_1000 + 4 * n_rows;
        tbl_dwait[n_rows] = dwait;
        tbl_ewait[n_rows] = ewait;
        tbl_en_rd[n_rows] = en_rd;
        tbl_lat[n_rows]   = lat;
        n_rows++;
    endtask

    // Latency counts accept to retire with the cache disabled
    // A RAW hazard at distance 1 adds 3 cycles
    task automatic build_table();
        add_row(enc_i(op_op_imm, 5'd1, 5'd0, 12'd5), 0, 0, 1'b1, 4);
        add_row(enc_i(op_op_imm, 5'd2, 5'd0, 12'd7), 0, 0, 1'b1, 4);
        add_row(enc_r(5'd3, 5'd1, 5'd2), 0, 0, 1'b1, 7);
        add_row(enc_i(op_op_imm, 5'd0, 5'd0, 12'd1), 0, 0, 1'b0, 4);
        add_row(enc_r(5'd4, 5'd0, 5'd0), 0, 0, 1'b1, 4);
        add_row(enc_i(op_load, 5'd5, 5'd4, 12'd0), 2, 0, 1'b1, 7);
        add_row(enc_s(5'd5, 5'd1, 5'd0), 1, 0, 1'b0, 7);
        add_row(mret_word, 0, 0, 1'b0, 7);
        add_row({20'h12345, 5'd6, op_lui}, 0, 0, 1'b1, 4);
        add_row(enc_i(op_op_imm, 5'd7, 5'd6, 12'd1), 0, 0, 1'b1, 7);
        add_row(ecall_word, 0, 3, 1'b0, 7);
        add_row(enc_i(op_op_imm, 5'd8, 5'd0, 12'd3), 0, 0, 1'b1, 4);
        add_row(enc_r(5'd9, 5'd8, 5'd8), 0, 0, 1'b1, 7);
        add_row(enc_i(op_load, 5'd10, 5'd0, 12'd0), 0, 0, 1'b1, 4);
        add_row(enc_s(5'd10, 5'd9, 5'd4), 0, 0, 1'b0, 7);
        add_row(enc_r(5'd11, 5'd10, 5'd9), 0, 0, 1'b1, 4);
        add_row(ecall_word, 0, 1, 1'b0, 5);
    endtask

    // Runs from one time unit after a rising edge to the same point one cycle later
    task automatic run_cycle();
        int r;
        inst_valid   = (row < num_rows);
        inst         = (row < num_rows) ? tbl_word[row] : 32'h0;
        inst_pc      = (row < num_rows) ? tbl_pc[row] : 32'h0;
        dcache_valid = mem_go;
        write_done   = mem_go;
        // The level of the access type not being waited on stays high
        if (dcache_enable && mem_q.size() > 0) begin
            if (tbl_word[mem_q[0]][6:0] == op_load) begin
                write_done = 1'b1;
            end else begin
                dcache_valid = 1'b1;
            end
        end
        // Hold an ecall in WB for its table count
        ecall_stall = flush_before_wb && (q.size() > 0) && (hold_cnt < tbl_ewait[q[0]]);
        if (ecall_stall) begin
            hold_cnt++;
        end
        #2;
        cyc++;
        check("inst_ready", inst_ready, !id_stall);
        check("wb_stall", wb_stall, ecall_stall);
        check("ex_stall", ex_stall, mem_stall);
        if (ecall_stall) begin
            check("mem_stall", mem_stall, 1'b1);
            check("retire_valid", retire_valid, 1'b0);
        end
        if (ex_stall) begin
            check("id_stall", id_stall, 1'b1);
        end
        if (!dcache_enable) begin
            check("mem_stall", mem_stall, ecall_stall);
        end
        // Cache model answers once the oldest load or store has waited long enough
        mem_go = 1'b0;
        if (dcache_enable && mem_stall && !wb_stall) begin
            if (mem_q.size() == 0) begin
                errors++;
                $display("Memory stall with no load or store outstanding at %0t", $time);
            end else begin
                mem_cnt++;
                if (mem_cnt >= wait_len[mem_q[0]]) begin
                    served[mem_q.pop_front()] = 1'b1;
                    mem_cnt = 0;
                    mem_go  = 1'b1;
                end
            end
        end
        if (retire_valid) begin
            if (q.size() == 0) begin
                errors++;
                $display("Retire seen with no instruction outstanding at %0t", $time);
            end else begin
                r = q.pop_front();
                check("retire_pc", retire_pc, tbl_pc[r]);
                check("retire_rd", retire_rd, tbl_word[r][11:7]);
                check("retire_en_rd", retire_en_rd, tbl_en_rd[r]);
                check("flush_before_wb", flush_before_wb, tbl_word[r] == ecall_word);
                if (dcache_enable) begin
                    check("latency_floor", (cyc - acc_cyc[r]) >= tbl_lat[r], 1'b1);
                    if (is_mem_op(tbl_word[r])) begin
                        check("mem_served", served[r], 1'b1);
                    end
                end else begin
                    check("latency", cyc - acc_cyc[r], tbl_lat[r]);
                end
                // Younger rows were squashed so fetch restarts behind the ecall
                if (tbl_word[r] == ecall_word) begin
                    check("ecall_hold", hold_cnt, tbl_ewait[r]);
                    q.delete();
                    mem_q.delete();
                    mem_cnt  = 0;
                    mem_go   = 1'b0;
                    hold_cnt = 0;
                    row      = r + 1;
                end
            end
        end else if (flush_before_wb) begin
            if (q.size() == 0) begin
                errors++;
                $display("Flush raised with no instruction outstanding at %0t", $time);
            end else begin
                check("wb_inst", tbl_word[q[0]], ecall_word);
            end
        end
        // An accept in a flush cycle is squashed in ID
        if (inst_valid && inst_ready && !flush_before_wb) begin
            q.push_back(row);
            acc_cyc[row] = cyc;
            served[row]  = 1'b0;
            if (dcache_enable && is_mem_op(tbl_word[row])) begin
                rng = xorshift(rng);
                wait_len[row] = (tbl_dwait[row] > 0) ? tbl_dwait[row] : 1 + rng % 4;
                mem_q.push_back(row);
            end
            row++;
        end
        @(posedge clk);
        #1;
    endtask

    initial begin
        rst           = 1'b1;
        inst_valid    = 1'b0;
        inst          = 32'h0;
        inst_pc       = 32'h0;
        dcache_enable = 1'b0;
        dcache_valid  = 1'b0;
        write_done    = 1'b0;
        ecall_stall   = 1'b0;
        errors        = 0;
        checks        = 0;
        cyc           = 0;
        build_table();
        repeat (10) @(posedge clk);
        #1;
        rst = 1'b0;
        #2;
        check("retire_valid", retire_valid, 1'b0);
        check("flush_before_wb", flush_before_wb, 1'b0);
        check("id_stall", id_stall, 1'b0);
        check("inst_ready", inst_ready, 1'b1);
        @(posedge clk);
        #1;
        for (pass = 0; pass < 2; pass++) begin
            dcache_enable = (pass == 0);
            row      = 0;
            mem_go   = 1'b0;
            mem_cnt  = 0;
            hold_cnt = 0;
            while (row < num_rows || q.size() > 0) begin
                run_cycle();
            end
        end
        $display("Checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

//--- verilog.f
rtl/pipe_pkg.sv
rtl/inst_decoder.sv
rtl/stage_reg.sv
rtl/hazard_unit.sv
rtl/pipeline_ctrl.sv
bench/tb_pipeline_ctrl.sv

//--- Bender.yml
package:
  name: pipeline_ctrl

sources:
  - rtl/pipe_pkg.sv
  - rtl/inst_decoder.sv
  - rtl/stage_reg.sv
  - rtl/hazard_unit.sv
  - rtl/pipeline_ctrl.sv
  - target: test
    files:
      - bench/tb_pipeline_ctrl.sv
